//--- src/bridge_pkg.sv
package bridge_pkg;

    localparam int LINE_WORDS    = 4;
    localparam int LINE_OFS_BITS = 4;   // 16 bytes per line
    localparam int ID_BITS       = 4;

    // transaction ids, one per requester
    localparam logic [ID_BITS-1:0] ID_ICACHE   = 4'd0;
    localparam logic [ID_BITS-1:0] ID_DCACHE   = 4'd1;
    localparam logic [ID_BITS-1:0] ID_UNCACHED = 4'd2;

    localparam logic [3:0] LEN_LINE   = 4'd3;   // four-beat INCR
    localparam logic [3:0] LEN_SINGLE = 4'd0;
    localparam logic [2:0] SIZE_WORD  = 3'd2;   // 4 bytes per beat

    typedef logic [31:0]               addr_t;
    typedef logic [31:0]               word_t;
    typedef word_t [LINE_WORDS-1:0]    line_t;  // word 0 at the low end
    typedef logic [31:LINE_OFS_BITS]   line_addr_t;
    typedef logic [ID_BITS-1:0]        axi_id_t;
    typedef logic [3:0]                axi_len_t;
    typedef logic [2:0]                axi_size_t;
    typedef logic [3:0]                strb_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
    } line_rd_req_t;

    typedef struct packed {
        logic      req;
        addr_t     addr;
        axi_size_t size;
    } word_rd_req_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
        line_t data;
    } line_wr_req_t;

    typedef struct packed {
        logic  req;
        addr_t addr;
        strb_t strb;
        word_t data;
    } word_wr_req_t;

    typedef struct packed {
        logic      valid;
        axi_id_t   id;
        addr_t     addr;
        axi_len_t  len;
        axi_size_t size;
    } axi_ar_t;

    // write address carries the same fields as read address
    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        logic    valid;
        axi_id_t id;
        word_t   data;
        logic    last;
    } axi_r_t;

    typedef struct packed {
        logic    valid;
        axi_id_t id;
        word_t   data;
        strb_t   strb;
        logic    last;
    } axi_w_t;

    typedef struct packed {
        logic    valid;
        axi_id_t id;
    } axi_b_t;

    typedef struct packed {
        logic       busy;
        line_addr_t line;
    } wr_pending_t;

endpackage

//--- src/read_channel_ctrl.sv
`timescale 1ns/100ps

module read_channel_ctrl (
    input  logic                     aclk,
    input  logic                     rst,
    input  bridge_pkg::line_rd_req_t icache_rd,
    input  bridge_pkg::line_rd_req_t dcache_rd,
    input  bridge_pkg::word_rd_req_t uncached_rd,
    input  bridge_pkg::wr_pending_t  wr_pending,
    input  logic                     arready,
    input  bridge_pkg::axi_r_t       r,
    output bridge_pkg::axi_ar_t      ar,
    output logic                     rready,
    output logic                     icache_rd_rdy,
    output logic                     icache_ret_valid,
    output logic                     dcache_rd_rdy,
    output logic                     dcache_ret_valid,
    output logic                     uncached_rd_rdy,
    output logic                     uncached_ret_valid,
    output bridge_pkg::line_t        line_data,
    output bridge_pkg::word_t        word_data
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    rd_state_e             state;
    logic                  dcache_go;
    logic                  uncached_go;
    logic                  icache_go;
    logic                  ar_done;
    logic                  beat_take;
    logic                  last_take;
    logic [1:0]            beat;
    bridge_pkg::axi_id_t   cur_id;
    bridge_pkg::addr_t     cur_addr;
    bridge_pkg::axi_len_t  cur_len;
    bridge_pkg::axi_size_t cur_size;
    bridge_pkg::line_t     line_buf;

    // true while a write to the same line is still outstanding
    function automatic logic line_blocked(
        input bridge_pkg::addr_t       a,
        input bridge_pkg::wr_pending_t p
    );
        return p.busy && (a[31:bridge_pkg::LINE_OFS_BITS] == p.line);
    endfunction

    function automatic bridge_pkg::addr_t line_base(input bridge_pkg::addr_t a);
        return {a[31:bridge_pkg::LINE_OFS_BITS], {bridge_pkg::LINE_OFS_BITS{1'b0}}};
    endfunction

    assign dcache_go   = dcache_rd.req && !line_blocked(dcache_rd.addr, wr_pending);
    assign uncached_go = uncached_rd.req && !line_blocked(uncached_rd.addr, wr_pending);
    assign icache_go   = icache_rd.req && !line_blocked(icache_rd.addr, wr_pending);

    assign ar_done   = (state == RD_ADDR) && arready;
    assign beat_take = (state == RD_DATA) && r.valid && (r.id == cur_id);
    assign last_take = beat_take && r.last;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (dcache_go || uncached_go || icache_go) begin
                        state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arready) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (last_take) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // winner capture in idle, beat gathering during data
    always_ff @(posedge aclk) begin
        if (state == RD_IDLE) begin
            beat <= '0;
            if (dcache_go) begin
                cur_id   <= bridge_pkg::ID_DCACHE;
                cur_addr <= line_base(dcache_rd.addr);
                cur_len  <= bridge_pkg::LEN_LINE;
                cur_size <= bridge_pkg::SIZE_WORD;
            end else if (uncached_go) begin
                cur_id   <= bridge_pkg::ID_UNCACHED;
                cur_addr <= uncached_rd.addr;
                cur_len  <= bridge_pkg::LEN_SINGLE;
                cur_size <= uncached_rd.size;
            end else if (icache_go) begin
                cur_id   <= bridge_pkg::ID_ICACHE;
                cur_addr <= line_base(icache_rd.addr);
                cur_len  <= bridge_pkg::LEN_LINE;
                cur_size <= bridge_pkg::SIZE_WORD;
            end
        end else if (beat_take) begin
            line_buf[beat] <= r.data;
            beat           <= beat + 2'd1;
        end
    end

    // one-cycle return pulse after the last beat
    always_ff @(posedge aclk) begin
        if (rst) begin
            icache_ret_valid   <= 1'b0;
            dcache_ret_valid   <= 1'b0;
            uncached_ret_valid <= 1'b0;
        end else begin
            icache_ret_valid   <= last_take && (cur_id == bridge_pkg::ID_ICACHE);
            dcache_ret_valid   <= last_take && (cur_id == bridge_pkg::ID_DCACHE);
            uncached_ret_valid <= last_take && (cur_id == bridge_pkg::ID_UNCACHED);
        end
    end

    always_comb begin
        ar.valid = (state == RD_ADDR);
        ar.id    = cur_id;
        ar.addr  = cur_addr;
        ar.len   = cur_len;
        ar.size  = cur_size;
    end

    assign rready = (state == RD_DATA);

    assign icache_rd_rdy   = ar_done && (cur_id == bridge_pkg::ID_ICACHE);
    assign dcache_rd_rdy   = ar_done && (cur_id == bridge_pkg::ID_DCACHE);
    assign uncached_rd_rdy = ar_done && (cur_id == bridge_pkg::ID_UNCACHED);

    assign line_data = line_buf;
    assign word_data = line_buf[0];   // single beat lands in word 0

endmodule

//--- src/write_channel_ctrl.sv
`timescale 1ns/100ps

module write_channel_ctrl (
    input  logic                     aclk,
    input  logic                     rst,
    input  bridge_pkg::line_wr_req_t dcache_wr,
    input  bridge_pkg::word_wr_req_t uncached_wr,
    input  logic                     awready,
    input  logic                     wready,
    input  bridge_pkg::axi_b_t       b,
    output bridge_pkg::axi_aw_t      aw,
    output bridge_pkg::axi_w_t       w,
    output logic                     bready,
    output logic                     dcache_wr_rdy,
    output logic                     dcache_wr_valid,
    output logic                     uncached_wr_rdy,
    output logic                     uncached_wr_valid,
    output bridge_pkg::wr_pending_t  wr_pending
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e            state;
    logic                 pick_any;
    logic                 aw_done;
    logic                 beat_take;
    logic                 beat_last;
    logic                 resp_take;
    logic [1:0]           beat;
    bridge_pkg::addr_t    pick_addr;
    bridge_pkg::axi_id_t  cur_id;
    bridge_pkg::addr_t    cur_addr;
    bridge_pkg::axi_len_t cur_len;
    bridge_pkg::strb_t    cur_strb;
    bridge_pkg::line_t    wbuf;

    // line write-back wins over uncached store
    assign pick_any  = dcache_wr.req || uncached_wr.req;
    assign pick_addr = dcache_wr.req ? dcache_wr.addr : uncached_wr.addr;

    assign aw_done   = (state == WR_ADDR) && awready;
    assign beat_last = (beat == cur_len[1:0]);
    assign beat_take = (state == WR_DATA) && wready;
    assign resp_take = (state == WR_RESP) && b.valid && (b.id == cur_id);

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (pick_any) begin
                        state <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (awready) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (beat_take && beat_last) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (resp_take) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == WR_IDLE) begin
            beat <= '0;
            if (dcache_wr.req) begin
                cur_id   <= bridge_pkg::ID_DCACHE;
                cur_addr <= {dcache_wr.addr[31:bridge_pkg::LINE_OFS_BITS],
                             {bridge_pkg::LINE_OFS_BITS{1'b0}}};
                cur_len  <= bridge_pkg::LEN_LINE;
                cur_strb <= 4'hf;
                wbuf     <= dcache_wr.data;
            end else if (uncached_wr.req) begin
                cur_id   <= bridge_pkg::ID_UNCACHED;
                cur_addr <= uncached_wr.addr;
                cur_len  <= bridge_pkg::LEN_SINGLE;
                cur_strb <= uncached_wr.strb;
                wbuf     <= {{(bridge_pkg::LINE_WORDS-1)*32{1'b0}}, uncached_wr.data};
            end
        end else if (beat_take) begin
            beat <= beat + 2'd1;
        end
    end

    // completion pulse one cycle after B
    always_ff @(posedge aclk) begin
        if (rst) begin
            dcache_wr_valid   <= 1'b0;
            uncached_wr_valid <= 1'b0;
        end else begin
            dcache_wr_valid   <= resp_take && (cur_id == bridge_pkg::ID_DCACHE);
            uncached_wr_valid <= resp_take && (cur_id == bridge_pkg::ID_UNCACHED);
        end
    end

    always_comb begin
        aw.valid = (state == WR_ADDR);
        aw.id    = cur_id;
        aw.addr  = cur_addr;
        aw.len   = cur_len;
        aw.size  = bridge_pkg::SIZE_WORD;
    end

    always_comb begin
        w.valid = (state == WR_DATA);
        w.id    = cur_id;
        w.data  = wbuf[beat];
        w.strb  = cur_strb;
        w.last  = beat_last;
    end

    assign bready = (state == WR_RESP);

    assign dcache_wr_rdy   = aw_done && (cur_id == bridge_pkg::ID_DCACHE);
    assign uncached_wr_rdy = aw_done && (cur_id == bridge_pkg::ID_UNCACHED);

    // the read side must already see the line on the cycle a write is taken
    always_comb begin
        if (state == WR_IDLE) begin
            wr_pending.busy = pick_any;
            wr_pending.line = pick_addr[31:bridge_pkg::LINE_OFS_BITS];
        end else begin
            wr_pending.busy = 1'b1;
            wr_pending.line = cur_addr[31:bridge_pkg::LINE_OFS_BITS];
        end
    end

endmodule

//--- src/axi_mem_bridge.sv
`timescale 1ns/100ps

module axi_mem_bridge (
    input  logic                     aclk,
    input  logic                     rst,

    // instruction cache
    input  bridge_pkg::line_rd_req_t icache_rd,
    output logic                     icache_rd_rdy,
    output logic                     icache_ret_valid,

    // data cache, refill and write-back
    input  bridge_pkg::line_rd_req_t dcache_rd,
    output logic                     dcache_rd_rdy,
    output logic                     dcache_ret_valid,
    input  bridge_pkg::line_wr_req_t dcache_wr,
    output logic                     dcache_wr_rdy,
    output logic                     dcache_wr_valid,

    // uncached word path
    input  bridge_pkg::word_rd_req_t uncached_rd,
    output logic                     uncached_rd_rdy,
    output logic                     uncached_ret_valid,
    input  bridge_pkg::word_wr_req_t uncached_wr,
    output logic                     uncached_wr_rdy,
    output logic                     uncached_wr_valid,

    output bridge_pkg::line_t        line_data,   // shared by both caches
    output bridge_pkg::word_t        word_data,

    // AXI master
    output bridge_pkg::axi_ar_t      ar,
    input  logic                     arready,
    input  bridge_pkg::axi_r_t       r,
    output logic                     rready,
    output bridge_pkg::axi_aw_t      aw,
    input  logic                     awready,
    output bridge_pkg::axi_w_t       w,
    input  logic                     wready,
    input  bridge_pkg::axi_b_t       b,
    output logic                     bready
);

    bridge_pkg::wr_pending_t wr_pending;   // line of the write in flight for the read hazard

    read_channel_ctrl i_read_channel_ctrl (
        .aclk               (aclk),
        .rst                (rst),
        .icache_rd          (icache_rd),
        .dcache_rd          (dcache_rd),
        .uncached_rd        (uncached_rd),
        .wr_pending         (wr_pending),
        .arready            (arready),
        .r                  (r),
        .ar                 (ar),
        .rready             (rready),
        .icache_rd_rdy      (icache_rd_rdy),
        .icache_ret_valid   (icache_ret_valid),
        .dcache_rd_rdy      (dcache_rd_rdy),
        .dcache_ret_valid   (dcache_ret_valid),
        .uncached_rd_rdy    (uncached_rd_rdy),
        .uncached_ret_valid (uncached_ret_valid),
        .line_data          (line_data),
        .word_data          (word_data)
    );

    write_channel_ctrl i_write_channel_ctrl (
        .aclk              (aclk),
        .rst               (rst),
        .dcache_wr         (dcache_wr),
        .uncached_wr       (uncached_wr),
        .awready           (awready),
        .wready            (wready),
        .b                 (b),
        .aw                (aw),
        .w                 (w),
        .bready            (bready),
        .dcache_wr_rdy     (dcache_wr_rdy),
        .dcache_wr_valid   (dcache_wr_valid),
        .uncached_wr_rdy   (uncached_wr_rdy),
        .uncached_wr_valid (uncached_wr_valid),
        .wr_pending        (wr_pending)
    );

endmodule

//--- verif/axi_slave_model.sv
`timescale 1ns/100ps

module axi_slave_model (
    input  logic                aclk,
    input  logic                rst,
    input  bridge_pkg::axi_ar_t ar,
    output logic                arready,
    output bridge_pkg::axi_r_t  r,
    input  logic                rready,
    input  bridge_pkg::axi_aw_t aw,
    output logic                awready,
    input  bridge_pkg::axi_w_t  w,
    output logic                wready,
    output bridge_pkg::axi_b_t  b,
    input  logic                bready
);

    bridge_pkg::word_t   mem [bridge_pkg::addr_t];   // only words written so far
    logic                rd_busy;
    logic                wr_busy;
    logic                wr_resp;
    bridge_pkg::addr_t   rd_addr;
    bridge_pkg::addr_t   wr_addr;
    bridge_pkg::axi_id_t rd_id;
    bridge_pkg::axi_id_t wr_id;
    logic [3:0]          rd_left;
    logic [1:0]          ar_dly;
    logic [1:0]          r_dly;
    logic [1:0]          aw_dly;
    logic [1:0]          w_dly;
    logic [1:0]          b_dly;

    function automatic bridge_pkg::word_t mem_read(input bridge_pkg::addr_t a);
        bridge_pkg::addr_t k;
        k = {a[31:2], 2'b00};
        if (mem.exists(k)) begin
            return mem[k];
        end
        return k ^ 32'ha5a5_0000;   // untouched words follow the fill pattern
    endfunction

    function automatic bridge_pkg::word_t merge(input bridge_pkg::word_t old_w,
                                                input bridge_pkg::word_t new_w,
                                                input bridge_pkg::strb_t s);
        bridge_pkg::word_t m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = s[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
        end
        return m;
    endfunction

    function automatic logic [1:0] rand_dly();
        logic [31:0] v;
        v = $urandom;
        return v[1:0];   // 0 to 3 cycles
    endfunction

    always @(posedge aclk) begin
        if (rst) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            r       <= '0;
            b       <= '0;
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
            wr_resp <= 1'b0;
            ar_dly  <= rand_dly();
            r_dly   <= rand_dly();
            aw_dly  <= rand_dly();
            w_dly   <= rand_dly();
            b_dly   <= rand_dly();
        end else begin
            if (ar.valid && arready) begin
                arready <= 1'b0;
                rd_busy <= 1'b1;
                rd_addr <= ar.addr;
                rd_id   <= ar.id;
                rd_left <= ar.len;
                ar_dly  <= rand_dly();
            end else if (ar.valid && !rd_busy) begin
                if (ar_dly == 2'd0) arready <= 1'b1;
                else ar_dly <= ar_dly - 2'd1;
            end

            if (r.valid && rready) begin
                r.valid <= 1'b0;
                r_dly   <= rand_dly();
                if (r.last) begin
                    rd_busy <= 1'b0;
                end else begin
                    rd_addr <= rd_addr + 32'd4;   // INCR burst
                    rd_left <= rd_left - 4'd1;
                end
            end else if (rd_busy && !r.valid) begin
                if (r_dly == 2'd0) begin
                    r.valid <= 1'b1;
                    r.id    <= rd_id;
                    r.data  <= mem_read(rd_addr);
                    r.last  <= (rd_left == 4'd0);
                end else begin
                    r_dly <= r_dly - 2'd1;
                end
            end

            if (aw.valid && awready) begin
                awready <= 1'b0;
                wr_busy <= 1'b1;
                wr_addr <= aw.addr;
                wr_id   <= aw.id;
                aw_dly  <= rand_dly();
            end else if (aw.valid && !wr_busy) begin
                if (aw_dly == 2'd0) awready <= 1'b1;
                else aw_dly <= aw_dly - 2'd1;
            end

            if (w.valid && wready) begin
                mem[{wr_addr[31:2], 2'b00}] = merge(mem_read(wr_addr), w.data, w.strb);
                wready  <= 1'b0;
                w_dly   <= rand_dly();
                wr_addr <= wr_addr + 32'd4;
                if (w.last) wr_resp <= 1'b1;
            end else if (w.valid && wr_busy && !wr_resp) begin
                if (w_dly == 2'd0) wready <= 1'b1;
                else w_dly <= w_dly - 2'd1;
            end

            if (b.valid && bready) begin
                b.valid <= 1'b0;
                wr_busy <= 1'b0;
                wr_resp <= 1'b0;
                b_dly   <= rand_dly();
            end else if (wr_resp && !b.valid) begin
                if (b_dly == 2'd0) begin
                    b.valid <= 1'b1;
                    b.id    <= wr_id;
                end else begin
                    b_dly <= b_dly - 2'd1;
                end
            end
        end
    end

endmodule

//--- verif/tb_axi_mem_bridge.sv
`timescale 1ns/100ps

module tb_axi_mem_bridge;

    localparam int NUM_ROWS = 7;
    localparam int TIMEOUT  = 200;

    // request kinds, also the first five row operations
    localparam logic [2:0] K_IREAD      = 3'd0;
    localparam logic [2:0] K_DREAD      = 3'd1;
    localparam logic [2:0] K_UREAD      = 3'd2;
    localparam logic [2:0] K_DWRITE     = 3'd3;
    localparam logic [2:0] K_UWRITE     = 3'd4;
    localparam logic [2:0] OP_WB_IREAD  = 3'd5;
    localparam logic [2:0] OP_ALL_READS = 3'd6;

    typedef struct packed {
        logic [2:0]            op;
        bridge_pkg::addr_t     addr;
        bridge_pkg::line_t     wdata;
        bridge_pkg::strb_t     strb;
        bridge_pkg::axi_size_t size;
        bridge_pkg::line_t     exp_data;
    } row_t;

    logic                     aclk;
    logic                     rst;
    bridge_pkg::line_rd_req_t icache_rd;
    bridge_pkg::line_rd_req_t dcache_rd;
    bridge_pkg::word_rd_req_t uncached_rd;
    bridge_pkg::line_wr_req_t dcache_wr;
    bridge_pkg::word_wr_req_t uncached_wr;
    logic                     icache_rd_rdy;
    logic                     icache_ret_valid;
    logic                     dcache_rd_rdy;
    logic                     dcache_ret_valid;
    logic                     uncached_rd_rdy;
    logic                     uncached_ret_valid;
    logic                     dcache_wr_rdy;
    logic                     dcache_wr_valid;
    logic                     uncached_wr_rdy;
    logic                     uncached_wr_valid;
    bridge_pkg::line_t        line_data;
    bridge_pkg::word_t        word_data;
    bridge_pkg::axi_ar_t      ar;
    logic                     arready;
    bridge_pkg::axi_r_t       r;
    logic                     rready;
    bridge_pkg::axi_aw_t      aw;
    logic                     awready;
    bridge_pkg::axi_w_t       w;
    logic                     wready;
    bridge_pkg::axi_b_t       b;
    logic                     bready;

    logic [9:0]          flags;   // rdy at 2*kind, done pulse at 2*kind+1
    bridge_pkg::axi_ar_t last_ar;
    bridge_pkg::axi_aw_t last_aw;
    row_t                rows [NUM_ROWS];
    int                  ret_cnt [3];
    int                  cycle = 0;
    int                  errors = 0;
    int                  passed = 0;
    int                  failed = 0;
    string flag_name [10] = '{"icache_rd_rdy", "icache_ret_valid", "dcache_rd_rdy",
                              "dcache_ret_valid", "uncached_rd_rdy", "uncached_ret_valid",
                              "dcache_wr_rdy", "dcache_wr_valid", "uncached_wr_rdy",
                              "uncached_wr_valid"};
    string row_name [NUM_ROWS] = '{"icache refill", "dcache write-back", "dcache refill",
                                   "uncached half write", "uncached read back",
                                   "write and refill same line", "three reads together"};

    assign flags = {uncached_wr_valid, uncached_wr_rdy, dcache_wr_valid, dcache_wr_rdy,
                    uncached_ret_valid, uncached_rd_rdy, dcache_ret_valid, dcache_rd_rdy,
                    icache_ret_valid, icache_rd_rdy};

    axi_mem_bridge i_axi_mem_bridge (.*);

    axi_slave_model i_axi_slave_model (.*);

    always #20 aclk = ~aclk;

    always @(posedge aclk) cycle <= cycle + 1;

    // address capture and return pulse count at mid cycle
    always @(negedge aclk) begin
        if (ar.valid && arready) begin
            last_ar = ar;
        end
        if (aw.valid && awready) begin
            last_aw = aw;
        end
        for (int k = 0; k < 3; k++) begin
            if (flags[2*k+1]) ret_cnt[k]++;
        end
    end

    function automatic bridge_pkg::word_t fill_word(input bridge_pkg::addr_t a);
        return a ^ 32'ha5a5_0000;
    endfunction

    function automatic bridge_pkg::line_t fill_line(input bridge_pkg::addr_t a);
        bridge_pkg::line_t l;
        for (int i = 0; i < bridge_pkg::LINE_WORDS; i++) begin
            l[i] = fill_word(a + 4 * i);
        end
        return l;
    endfunction

    task automatic check(input string sig, input logic [127:0] exp, input logic [127:0] got);
        if (got !== exp) begin
            $display("ERROR at %0t: %s expected %h got %h", $time, sig, exp, got);
            errors++;
        end
    endtask

    task automatic wait_flag(input int idx, output logic seen, output int at);
        int n;
        seen = 1'b0;
        at   = -1;
        n    = 0;
        while (!seen && n < TIMEOUT) begin
            @(negedge aclk);
            n++;
            if (flags[idx]) begin
                seen = 1'b1;
                at   = cycle;
            end
        end
        if (!seen) begin
            $display("%s never rose within %0d cycles", flag_name[idx], TIMEOUT);
            errors++;
        end
    endtask

    task automatic set_req(input logic [2:0] kind, input bridge_pkg::addr_t a,
                           input row_t rw, input logic on);
        case (kind)
            K_IREAD:  icache_rd   = {on, a};
            K_DREAD:  dcache_rd   = {on, a};
            K_UREAD:  uncached_rd = {on, a, rw.size};
            K_DWRITE: dcache_wr   = {on, a, rw.wdata};
            default:  uncached_wr = {on, a, rw.strb, rw.wdata[0]};
        endcase
    endtask

    // one requester raises, holds until rdy, drops, then waits for completion
    task automatic do_req(input logic [2:0] kind, input bridge_pkg::addr_t a, input row_t rw,
                          output bridge_pkg::line_t got, output int rdy_at, output int done_at);
        logic seen;
        done_at = -1;
        @(posedge aclk);
        #2;
        set_req(kind, a, rw, 1'b1);
        wait_flag(2 * kind, seen, rdy_at);
        @(posedge aclk);
        #2;
        set_req(kind, a, rw, 1'b0);
        if (seen) wait_flag(2 * kind + 1, seen, done_at);
        got = (kind == K_UREAD) ? {96'b0, word_data} : line_data;
    endtask

    task automatic report(input string name, input int err0);
        if (errors == err0) begin
            passed++;
            $display("%-28s ok", name);
        end else begin
            failed++;
            $display("%-28s FAILED", name);
        end
    endtask

    task automatic run_row(input int idx, input row_t rw);
        int                err0;
        int                rdy_a;
        int                rdy_b;
        int                rdy_c;
        int                done_a;
        int                done_b;
        int                done_c;
        bridge_pkg::line_t got_a;
        bridge_pkg::line_t got_b;
        bridge_pkg::line_t got_c;
        err0 = errors;
        case (rw.op)
            K_IREAD, K_DREAD: begin
                do_req(rw.op, rw.addr, rw, got_a, rdy_a, done_a);
                check("line_data", rw.exp_data, got_a);
                if (rw.op == K_IREAD) begin
                    check("arid", bridge_pkg::ID_ICACHE, last_ar.id);
                    check("arlen", 3, last_ar.len);
                end
            end
            K_UREAD: begin
                do_req(rw.op, rw.addr, rw, got_a, rdy_a, done_a);
                check("word_data", rw.exp_data, got_a);
                check("arsize", rw.size, last_ar.size);
            end
            K_DWRITE, K_UWRITE: begin
                do_req(rw.op, rw.addr, rw, got_a, rdy_a, done_a);
                check("awlen", (rw.op == K_DWRITE) ? 3 : 0, last_aw.len);
                check("awsize", 2, last_aw.size);
            end
            OP_WB_IREAD: begin
                fork
                    do_req(K_DWRITE, rw.addr, rw, got_a, rdy_a, done_a);
                    do_req(K_IREAD, rw.addr, rw, got_b, rdy_b, done_b);
                join
                check("line_data", rw.exp_data, got_b);
                if (done_b <= done_a) begin
                    $display("refill of the written line returned before the write-back ended");
                    errors++;
                end
            end
            default: begin
                @(posedge aclk);
                #2;
                ret_cnt = '{0, 0, 0};
                fork
                    do_req(K_DREAD, rw.addr, rw, got_a, rdy_a, done_a);
                    do_req(K_UREAD, rw.addr + 32'h40, rw, got_b, rdy_b, done_b);
                    do_req(K_IREAD, rw.addr + 32'h80, rw, got_c, rdy_c, done_c);
                join
                repeat (4) @(posedge aclk);   // room for a stray second pulse
                check("line_data", rw.exp_data, got_a);
                check("word_data", {96'b0, fill_word(rw.addr + 32'h40)}, got_b);
                check("line_data", fill_line(rw.addr + 32'h80), got_c);
                for (int k = 0; k < 3; k++) begin
                    check(flag_name[2*k+1], 1, ret_cnt[k]);
                end
                if (rdy_a >= rdy_b || rdy_a >= rdy_c) begin
                    $display("data cache refill was not the first read accepted");
                    errors++;
                end
            end
        endcase
        report(row_name[idx], err0);
    endtask

    initial begin
        int err0;
        void'($urandom(32'h5252f88c));
        aclk        = 1'b0;
        rst         = 1'b1;
        icache_rd   = '0;
        dcache_rd   = '0;
        uncached_rd = '0;
        dcache_wr   = '0;
        uncached_wr = '0;
        ret_cnt     = '{0, 0, 0};

        rows[0] = '{K_IREAD, 32'h1000, '0, 4'hf, 3'd2, fill_line(32'h1000)};
        rows[1] = '{K_DWRITE, 32'h2000,
                    {32'hc0de_0003, 32'hc0de_0002, 32'hc0de_0001, 32'hc0de_0000},
                    4'hf, 3'd2, '0};
        rows[2] = '{K_DREAD, 32'h2000, '0, 4'hf, 3'd2,
                    {32'hc0de_0003, 32'hc0de_0002, 32'hc0de_0001, 32'hc0de_0000}};
        rows[3] = '{K_UWRITE, 32'h3004, {96'b0, 32'h1234_5678}, 4'b0011, 3'd2, '0};
        rows[4] = '{K_UREAD, 32'h3004, '0, 4'hf, 3'd1,
                    {96'b0, (fill_word(32'h3004) & 32'hffff_0000) | 32'h0000_5678}};
        rows[5] = '{OP_WB_IREAD, 32'h4000,
                    {32'hbeef_4444, 32'hbeef_3333, 32'hbeef_2222, 32'hbeef_1111},
                    4'hf, 3'd2,
                    {32'hbeef_4444, 32'hbeef_3333, 32'hbeef_2222, 32'hbeef_1111}};
        rows[6] = '{OP_ALL_READS, 32'h5000, '0, 4'hf, 3'd2, fill_line(32'h5000)};

        repeat (3) @(posedge aclk);
        #2;
        rst = 1'b0;

        err0 = errors;
        @(negedge aclk);
        check("valid, ready and pulse outputs", 0,
              {ar.valid, aw.valid, w.valid, rready, bready, flags});
        report("reset state", err0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i, rows[i]);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 passed + failed, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- list.f
src/bridge_pkg.sv
src/read_channel_ctrl.sv
src/write_channel_ctrl.sv
src/axi_mem_bridge.sv
verif/axi_slave_model.sv
verif/tb_axi_mem_bridge.sv

//--- Bender.yml
package:
  name: axi_mem_bridge

sources:
  - src/bridge_pkg.sv
  - src/read_channel_ctrl.sv
  - src/write_channel_ctrl.sv
  - src/axi_mem_bridge.sv
  - target: test
    files:
      - verif/axi_slave_model.sv
      - verif/tb_axi_mem_bridge.sv
